// ==== src/lanzonesPkg.sv ====
package lanzonesPkg;

   typedef logic [31:0] xlenT;
   typedef logic [4:0]  regAddrT;

   // Major opcodes, bits [6:0]
   localparam logic [6:0] opLui   = 7'b0110111;
   localparam logic [6:0] opOp    = 7'b0110011;
   localparam logic [6:0] opOpImm = 7'b0010011;
   localparam logic [6:0] opLoad  = 7'b0000011;
   localparam logic [6:0] opStore = 7'b0100011;
   localparam logic [6:0] opHalt  = 7'b1111111;

   typedef enum logic [3:0] {
      aluAdd,
      aluSub,
      aluXor,
      aluOr,
      aluAnd,
      aluSll,
      aluSrl,
      aluSra,
      aluPassB   // LUI
   } aluOpT;

   typedef struct packed {
      aluOpT   aluOp;
      logic    useImm;     // Operand B is imm
      xlenT    imm;        // Already extended or shifted
      regAddrT rs1;
      regAddrT rs2;
      regAddrT rd;
      logic    regWrite;
      logic    isLoad;
      logic    isStore;
      logic    isHalt;
   } decodedInstrT;

endpackage

// ==== src/regFileIf.sv ====
`timescale 1ns/1ps

interface regFileIf import lanzonesPkg::*; ();

   regAddrT rs1Addr;
   regAddrT rs2Addr;
   xlenT    rs1Data;
   xlenT    rs2Data;
   logic    wrEn;
   regAddrT wrAddr;
   xlenT    wrData;

   modport seq (
      output rs1Addr, rs2Addr, wrEn, wrAddr, wrData,
      input  rs1Data, rs2Data
   );

   modport rf (
      input  rs1Addr, rs2Addr, wrEn, wrAddr, wrData,
      output rs1Data, rs2Data
   );

endinterface

// ==== src/regFile.sv ====
`timescale 1ns/1ps

module regFile import lanzonesPkg::*; (
   input logic   clk,
   input logic   rstn,
   regFileIf.rf  regs
);

   // x1..x31 only, x0 has no storage
   xlenT regArr [1:31];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 1; i < 32; i++) begin
            regArr[i] <= '0;
         end
      end
      else begin
         if (regs.wrEn && (regs.wrAddr != '0)) begin
            regArr[regs.wrAddr] <= regs.wrData;
         end
      end
   end

   assign regs.rs1Data = (regs.rs1Addr == '0) ? '0 : regArr[regs.rs1Addr];
   assign regs.rs2Data = (regs.rs2Addr == '0) ? '0 : regArr[regs.rs2Addr];

endmodule

// ==== src/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder import lanzonesPkg::*; (
   input  xlenT         instrWord,
   output decodedInstrT dec
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   xlenT       immI;
   xlenT       immS;
   xlenT       immShamt;
   xlenT       immU;

   assign opcode = instrWord[6:0];
   assign funct3 = instrWord[14:12];
   assign funct7 = instrWord[31:25];

   assign immI     = {{20{instrWord[31]}}, instrWord[31:20]};
   assign immS     = {{20{instrWord[31]}}, instrWord[31:25], instrWord[11:7]};
   assign immShamt = {27'b0, instrWord[24:20]};
   assign immU     = {instrWord[31:12], 12'b0};

   always_comb begin
      dec = '0;
      dec.aluOp = aluAdd;
      dec.rs1 = instrWord[19:15];
      dec.rs2 = instrWord[24:20];
      dec.rd = instrWord[11:7];

      case (opcode)
         opOp: begin
            dec.regWrite = 1'b1;
            if (funct7 == 7'b0000000) begin
               case (funct3)
                  3'b000:  dec.aluOp = aluAdd;
                  3'b001:  dec.aluOp = aluSll;
                  3'b100:  dec.aluOp = aluXor;
                  3'b110:  dec.aluOp = aluOr;
                  3'b111:  dec.aluOp = aluAnd;
                  default: dec.regWrite = 1'b0;
               endcase
            end
            else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
               dec.aluOp = aluSub;
            end
            else begin
               dec.regWrite = 1'b0;
            end
         end
         opOpImm: begin
            dec.useImm = 1'b1;
            dec.imm = immI;
            dec.regWrite = 1'b1;
            case (funct3)
               3'b000: dec.aluOp = aluAdd;
               3'b100: dec.aluOp = aluXor;
               3'b110: dec.aluOp = aluOr;
               3'b111: dec.aluOp = aluAnd;
               3'b001: begin
                  dec.imm = immShamt;
                  dec.aluOp = aluSll;
                  dec.regWrite = (funct7 == 7'b0000000);
               end
               3'b101: begin
                  dec.imm = immShamt;
                  dec.aluOp = funct7[5] ? aluSra : aluSrl;
                  dec.regWrite = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
               end
               default: dec.regWrite = 1'b0;
            endcase
         end
         opLui: begin
            dec.aluOp = aluPassB;
            dec.useImm = 1'b1;
            dec.imm = immU;
            dec.regWrite = 1'b1;
         end
         opLoad: begin
            dec.useImm = 1'b1;
            dec.imm = immI;
            dec.isLoad = (funct3 == 3'b010);    // LW only
            dec.regWrite = (funct3 == 3'b010);
         end
         opStore: begin
            dec.useImm = 1'b1;
            dec.imm = immS;
            dec.isStore = (funct3 == 3'b010);
         end
         opHalt:  dec.isHalt = 1'b1;
         default: dec.regWrite = 1'b0;   // Unknown encodings are no-ops
      endcase
   end

endmodule

// ==== src/execAlu.sv ====
`timescale 1ns/1ps

module execAlu import lanzonesPkg::*; (
   input  decodedInstrT dec,
   input  xlenT         rs1Data,
   input  xlenT         rs2Data,
   output xlenT         aluResult
);

   xlenT       opB;
   logic [4:0] shamt;

   assign opB = dec.useImm ? dec.imm : rs2Data;
   assign shamt = opB[4:0];

   always_comb begin
      case (dec.aluOp)
         aluAdd:   aluResult = rs1Data + opB;   // Also LW/SW address
         aluSub:   aluResult = rs1Data - opB;
         aluXor:   aluResult = rs1Data ^ opB;
         aluOr:    aluResult = rs1Data | opB;
         aluAnd:   aluResult = rs1Data & opB;
         aluSll:   aluResult = rs1Data << shamt;
         aluSrl:   aluResult = rs1Data >> shamt;
         aluSra:   aluResult = xlenT'($signed(rs1Data) >>> shamt);
         aluPassB: aluResult = opB;
         default:  aluResult = '0;
      endcase
   end

endmodule

// ==== src/coreSequencer.sv ====
`timescale 1ns/1ps

module coreSequencer import lanzonesPkg::*; #(
   parameter xlenT ResetPc = '0
) (
   input  logic         clk,
   input  logic         rstn,
   input  logic         RVld,
   input  xlenT         RData,
   input  logic         LEn,
   output logic         RRdy,
   output xlenT         RAddr,
   output logic         RWEn,
   output xlenT         RWData,
   output logic         Halt,
   output xlenT         instrWord,
   input  decodedInstrT dec,
   input  xlenT         aluResult,
   regFileIf.seq        regs
);

   typedef enum logic [1:0] {
      stIdle,
      stFetch,
      stExec,
      stMem
   } seqStateT;

   seqStateT state;
   xlenT     pc;         // Word address
   xlenT     instrReg;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= stIdle;
         pc <= ResetPc;
         Halt <= 1'b1;
      end
      else begin
         case (state)
            stIdle: begin
               // Resume one cycle after Halt drops
               if (Halt) begin
                  if (LEn) begin
                     Halt <= 1'b0;
                  end
               end
               else begin
                  state <= stFetch;
               end
            end
            stFetch: begin
               if (RVld) begin
                  state <= stExec;
               end
            end
            stExec: begin
               pc <= pc + 32'd1;
               if (dec.isLoad || dec.isStore) begin
                  state <= stMem;
               end
               else if (dec.isHalt) begin
                  Halt <= 1'b1;
                  state <= stIdle;
               end
               else begin
                  state <= stFetch;
               end
            end
            stMem: begin
               if (RVld) begin
                  state <= stFetch;
               end
            end
            default: state <= stIdle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == stFetch && RVld) begin
         instrReg <= RData;
      end
   end

   assign instrWord = instrReg;

   // Memory port, held steady until RVld
   assign RRdy = (state == stFetch) || (state == stMem);
   assign RAddr = (state == stMem) ? aluResult : pc;
   assign RWEn = (state == stMem) && dec.isStore;
   assign RWData = regs.rs2Data;

   assign regs.rs1Addr = dec.rs1;
   assign regs.rs2Addr = dec.rs2;

   // ALU result in EXEC, load data on the LW response
   assign regs.wrEn = ((state == stExec) && dec.regWrite && !dec.isLoad) ||
                      ((state == stMem) && dec.isLoad && RVld);
   assign regs.wrAddr = dec.rd;
   assign regs.wrData = (state == stMem) ? RData : aluResult;

endmodule

// ==== src/lanzonesCore.sv ====
`timescale 1ns/1ps

module lanzonesCore import lanzonesPkg::*; #(
   parameter xlenT ResetPc = '0
) (
   input  logic clk,
   input  logic rstn,
   input  logic RVld,
   input  xlenT RData,
   output xlenT RWData,
   output logic RWEn,
   output logic RRdy,
   output xlenT RAddr,
   output logic Halt,
   input  logic LEn
);

   xlenT         instrWord;
   decodedInstrT dec;
   xlenT         aluResult;

   regFileIf rfBus ();

   coreSequencer #(
      .ResetPc (ResetPc)
   ) i_seq (
      .clk       (clk),
      .rstn      (rstn),
      .RVld      (RVld),
      .RData     (RData),
      .LEn       (LEn),
      .RRdy      (RRdy),
      .RAddr     (RAddr),
      .RWEn      (RWEn),
      .RWData    (RWData),
      .Halt      (Halt),
      .instrWord (instrWord),
      .dec       (dec),
      .aluResult (aluResult),
      .regs      (rfBus.seq)
   );

   instrDecoder i_dec (
      .instrWord (instrWord),
      .dec       (dec)
   );

   execAlu i_alu (
      .dec       (dec),
      .rs1Data   (rfBus.rs1Data),
      .rs2Data   (rfBus.rs2Data),
      .aluResult (aluResult)
   );

   regFile i_regFile (
      .clk  (clk),
      .rstn (rstn),
      .regs (rfBus.rf)
   );

endmodule

// ==== tb/isaModel.svh ====
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

localparam xlenT haltWord = 32'h0000007F;

xlenT modelMem [0:255];
xlenT modelRegs [0:31];
xlenT expAddr [$];        // Expected requests in order
logic expWEn [$];
xlenT expWData [$];
int   modelStoreCount;

function automatic xlenT randomInstr();
   logic [31:0] r;
   logic [31:0] s;
   logic [4:0]  rd;
   logic [4:0]  rs1;
   logic [4:0]  rs2;
   logic [11:0] imm;
   logic [11:0] dataImm;
   logic [2:0]  sel;
   logic [2:0]  f3;
   logic [6:0]  f7;
   xlenT        instr;
   r = nextRandom();
   s = nextRandom();
   rd = {2'b00, r[2:0]};   // x0..x7, so x0 shows up as a target
   rs1 = {2'b00, r[5:3]};
   rs2 = {2'b00, r[8:6]};
   imm = r[20:9];
   sel = s[10:8];
   dataImm = {5'b00001, s[6:0]};   // Words 128..255
   f3 = 3'b000;
   f7 = 7'b0000000;
   case (r[24:21])
      4'd0, 4'd1, 4'd2, 4'd3: begin
         case (sel)
            3'd1, 3'd7: f7 = 7'b0100000;   // SUB
            3'd2: f3 = 3'b100;
            3'd3: f3 = 3'b110;
            3'd4: f3 = 3'b111;
            3'd5: f3 = 3'b001;
            default: f3 = 3'b000;
         endcase
         instr = {f7, rs2, rs1, f3, rd, 7'b0110011};
      end
      4'd4, 4'd5, 4'd6: begin
         case (sel[1:0])
            2'd1: f3 = 3'b100;
            2'd2: f3 = 3'b110;
            2'd3: f3 = 3'b111;
            default: f3 = 3'b000;
         endcase
         instr = {imm, rs1, f3, rd, 7'b0010011};
      end
      4'd7, 4'd8: begin
         f3 = (sel < 3'd3) ? 3'b001 : 3'b101;
         f7 = (sel > 3'd5) ? 7'b0100000 : 7'b0000000;   // SRAI
         instr = {f7, s[15:11], rs1, f3, rd, 7'b0010011};
      end
      4'd9, 4'd10: instr = {s[31:12], rd, 7'b0110111};
      4'd11, 4'd12: instr = {dataImm, 5'd0, 3'b010, rd, 7'b0000011};
      default: instr = {dataImm[11:5], rs2, 5'd0, 3'b010, dataImm[4:0], 7'b0100011};
   endcase
   return instr;
endfunction

task automatic buildImage();
   for (int i = 0; i < 256; i++) begin
      if (i == 63 || i == 127) begin
         modelMem[i] = haltWord;   // Segment ends
      end
      else if (i < 128) begin
         modelMem[i] = randomInstr();
      end
      else begin
         modelMem[i] = nextRandom();
      end
   end
   for (int i = 0; i < 32; i++) begin
      modelRegs[i] = '0;
   end
   modelStoreCount = 0;
endtask

task automatic pushRequest(input xlenT addr, input logic wEn, input xlenT wData);
   expAddr.push_back(addr);
   expWEn.push_back(wEn);
   expWData.push_back(wData);
endtask

// Runs from startPc up to and including the next halt instruction
task automatic modelRunSegment(input xlenT startPc, output xlenT haltPc);
   xlenT       pc;
   xlenT       instr;
   xlenT       a;
   xlenT       b;
   xlenT       res;
   xlenT       addr;
   logic       wr;
   logic       done;
   logic [4:0] rd;
   logic [2:0] f3;
   logic [6:0] f7;
   pc = startPc;
   haltPc = '0;
   done = 1'b0;
   for (int step = 0; step < 200 && !done; step++) begin
      instr = modelMem[pc[7:0]];
      pushRequest(pc, 1'b0, '0);
      rd = instr[11:7];
      f3 = instr[14:12];
      f7 = instr[31:25];
      a = modelRegs[instr[19:15]];
      b = modelRegs[instr[24:20]];
      wr = 1'b0;
      res = '0;
      case (instr[6:0])
         7'b0110011: begin
            wr = 1'b1;
            case (f3)
               3'b000: res = f7[5] ? a - b : a + b;
               3'b001: res = a << b[4:0];
               3'b100: res = a ^ b;
               3'b110: res = a | b;
               default: res = a & b;
            endcase
         end
         7'b0010011: begin
            wr = 1'b1;
            b = {{20{instr[31]}}, instr[31:20]};
            case (f3)
               3'b000: res = a + b;
               3'b100: res = a ^ b;
               3'b110: res = a | b;
               3'b111: res = a & b;
               3'b001: res = a << instr[24:20];
               default: res = f7[5] ? xlenT'($signed(a) >>> instr[24:20]) : a >> instr[24:20];
            endcase
         end
         7'b0110111: begin
            wr = 1'b1;
            res = {instr[31:12], 12'b0};
         end
         7'b0000011: begin
            wr = 1'b1;
            addr = a + {{20{instr[31]}}, instr[31:20]};
            pushRequest(addr, 1'b0, '0);
            res = modelMem[addr[7:0]];
         end
         7'b0100011: begin
            addr = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
            pushRequest(addr, 1'b1, b);
            modelMem[addr[7:0]] = b;
            modelStoreCount++;
         end
         7'b1111111: begin
            done = 1'b1;
            haltPc = pc;
         end
         default: wr = 1'b0;
      endcase
      if (wr && rd != 5'd0) begin
         modelRegs[rd] = res;
      end
      pc = pc + 32'd1;
   end
   if (!done) begin
      stopWithFailure("The reference model ran past the end of the segment without a halt");
   end
endtask

`endif

// ==== tb/tbLanzones.sv ====
`timescale 1ns/1ps

module tbLanzones import lanzonesPkg::*; ();

   logic clk;
   logic rstn;
   logic RVld;
   xlenT RData;
   xlenT RWData;
   logic RWEn;
   logic RRdy;
   xlenT RAddr;
   logic Halt;
   logic LEn;

   logic [31:0] rngState;
   xlenT        memArr [0:255];   // Memory seen by the DUT
   xlenT        nextPc;
   int          storesSeen;

   function automatic logic [31:0] nextRandom();
      rngState = rngState ^ (rngState << 13);
      rngState = rngState ^ (rngState >> 17);
      rngState = rngState ^ (rngState << 5);
      return rngState;
   endfunction

   task automatic stopWithFailure(input string what);
      $display("%s", what);
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped");
   endtask

   task automatic checkWord(input string name, input xlenT actual, input xlenT expected);
      if (actual !== expected) begin
         stopWithFailure($sformatf("Error at %0t ns: %s is %h, expected %h",
                                   $time, name, actual, expected));
      end
   endtask

   task automatic checkBit(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         stopWithFailure($sformatf("Error at %0t ns: %s is %b, expected %b",
                                   $time, name, actual, expected));
      end
   endtask

   `include "isaModel.svh"

   lanzonesCore #(
      .ResetPc (32'd0)
   ) i_dut (
      .clk    (clk),
      .rstn   (rstn),
      .RVld   (RVld),
      .RData  (RData),
      .RWData (RWData),
      .RWEn   (RWEn),
      .RRdy   (RRdy),
      .RAddr  (RAddr),
      .Halt   (Halt),
      .LEn    (LEn)
   );

   always #2 clk = ~clk;

   task automatic checkIdle(input int cycles);
      for (int i = 0; i < cycles; i++) begin
         @(posedge clk);
         #1;
         checkBit("Halt", Halt, 1'b1);
         checkBit("RRdy", RRdy, 1'b0);
         checkBit("RWEn", RWEn, 1'b0);
      end
   endtask

   // Entered 1 ns after an edge with RRdy high and returns 1 ns after the RVld edge
   task automatic serveRequest();
      xlenT reqAddr;
      logic reqWEn;
      xlenT reqWData;
      xlenT expData;
      int   lat;
      reqAddr = RAddr;
      reqWEn = RWEn;
      reqWData = RWData;
      if (expAddr.size() == 0) begin
         stopWithFailure($sformatf("Unexpected memory request at %0t ns to address %h",
                                   $time, reqAddr));
      end
      checkWord("RAddr", reqAddr, expAddr.pop_front());
      checkBit("RWEn", reqWEn, expWEn.pop_front());
      expData = expWData.pop_front();
      if (reqWEn) begin
         checkWord("RWData", reqWData, expData);
         storesSeen++;
      end
      lat = 1 + int'(nextRandom() % 32'd5);
      for (int i = 1; i < lat; i++) begin
         @(posedge clk);
         #1;
         checkBit("RRdy", RRdy, 1'b1);   // Held until RVld
         checkWord("RAddr", RAddr, reqAddr);
         checkBit("RWEn", RWEn, reqWEn);
         if (reqWEn) begin
            checkWord("RWData", RWData, reqWData);
         end
      end
      RVld = 1'b1;
      if (reqWEn) begin
         memArr[reqAddr[7:0]] = reqWData;
         RData = nextRandom();
      end
      else begin
         RData = memArr[reqAddr[7:0]];
      end
      @(posedge clk);
      #1;
      RVld = 1'b0;
      RData = nextRandom();   // Garbage outside RVld
   endtask

   task automatic runSegment();
      xlenT haltPc;
      int   cycles;
      modelRunSegment(nextPc, haltPc);
      LEn = 1'b1;
      @(posedge clk);
      #1;
      LEn = 1'b0;
      checkBit("Halt", Halt, 1'b0);
      cycles = 0;
      while (Halt !== 1'b1 || RRdy !== 1'b0) begin
         if (cycles > 5000) begin
            stopWithFailure("Timeout: the core did not reach the halt instruction");
         end
         if (RRdy === 1'b1) begin
            serveRequest();
         end
         else begin
            @(posedge clk);
            #1;
         end
         cycles++;
      end
      if (expAddr.size() != 0) begin
         stopWithFailure($sformatf("Halt rose at %0t ns with %0d expected requests still missing",
                                   $time, expAddr.size()));
      end
      nextPc = haltPc + 32'd1;
   endtask

   initial begin
      clk = 1'b0;
      rstn = 1'b0;
      LEn = 1'b0;
      RVld = 1'b0;
      RData = '0;
      rngState = 32'd33199;
      nextPc = '0;
      storesSeen = 0;
      buildImage();
      for (int i = 0; i < 256; i++) begin
         memArr[i] = modelMem[i];
      end
      repeat (4) @(posedge clk);
      #1;
      rstn = 1'b1;
      checkIdle(20);
      runSegment();
      checkIdle(20);   // Quiet after halt
      runSegment();
      checkIdle(20);
      if (storesSeen == modelStoreCount) begin
         $display("TEST PASSED");
         $finish;
      end
      else begin
         stopWithFailure($sformatf("Error at %0t ns: store count is %0d, expected %0d",
                                   $time, storesSeen, modelStoreCount));
      end
   end

endmodule

// ==== vlog.f ====
+incdir+tb
src/lanzonesPkg.sv
src/regFileIf.sv
src/regFile.sv
src/instrDecoder.sv
src/execAlu.sv
src/coreSequencer.sv
src/lanzonesCore.sv
tb/tbLanzones.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -f vlog.f --top-module tbLanzones -Mdir obj_dir &&
./obj_dir/VtbLanzones ||
exit 1
